// File: src/tetris_pkg.sv
// shared types and register map for the APB playfield core
// row 0 is the top of the playfield, row pf_rows-1 the bottom
package tetris_pkg;

    localparam int pf_rows = 20;
    localparam int pf_cols = 10;

    typedef logic [4:0] row_idx_t;
    typedef logic [pf_cols-1:0] row_mask_t;

    typedef enum logic [3:0] {
        tile_blank   = 4'd0,
        piece_i      = 4'd1,
        piece_j      = 4'd2,
        piece_l      = 4'd3,
        piece_o      = 4'd4,
        piece_s      = 4'd5,
        piece_t      = 4'd6,
        piece_z      = 4'd7,
        tile_garbage = 4'd8
    } tile_t;

    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_play    = 3'd1,
        st_clear   = 3'd2,
        st_garbage = 3'd3,
        st_over    = 3'd4
    } game_state_t;

    typedef struct packed {
        logic [5:0] minutes;
        logic [5:0] seconds;
        logic [6:0] centiseconds;
    } game_time_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic       start;
        logic       stop;
        logic       lock;
        row_idx_t   lock_row;
        row_mask_t  lock_mask;
        tile_t      lock_tile;
        logic       garbage;
        logic [4:0] garbage_count;
        logic [3:0] garbage_hole;
    } host_cmd_t;

    typedef struct packed {
        logic       clear_all;
        logic       write_row;
        row_idx_t   row;
        row_mask_t  mask;
        tile_t      tile;
        logic       remove_row;
        row_idx_t   remove_idx;
        logic       push_garbage;
        logic [3:0] hole;
    } pf_op_t;

    localparam logic [7:0] addr_ctrl     = 8'h00;
    localparam logic [7:0] addr_status   = 8'h04;
    localparam logic [7:0] addr_lock     = 8'h08;
    localparam logic [7:0] addr_garbage  = 8'h0C;
    localparam logic [7:0] addr_lines    = 8'h10;
    localparam logic [7:0] addr_timer    = 8'h14;
    localparam logic [7:0] addr_row_base = 8'h40;

endpackage

// File: src/apb_regs.sv
// APB slave, read data is captured in the setup phase and valid in access
// command writes stall while the game FSM is busy, reads never stall
`timescale 1ns/100ps

module apb_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  tetris_pkg::apb_req_t    apb,
    output logic [31:0]             prdata,
    output logic                    pready,
    input  logic                    cmd_ready,
    output tetris_pkg::host_cmd_t   cmd,
    input  tetris_pkg::game_state_t state,
    input  logic [15:0]             lines_cleared,
    input  tetris_pkg::game_time_t  game_time,
    input  tetris_pkg::row_mask_t   row_masks [tetris_pkg::pf_rows]
);

    logic        is_cmd_addr;
    logic        wr_done;
    logic        busy;
    logic [7:0]  row_off;
    logic [4:0]  row_sel;
    logic        row_hit;
    logic [31:0] rd_mux;

    assign is_cmd_addr = (apb.paddr == tetris_pkg::addr_ctrl) ||
                         (apb.paddr == tetris_pkg::addr_lock) ||
                         (apb.paddr == tetris_pkg::addr_garbage);

    assign pready  = !(apb.psel && apb.pwrite && is_cmd_addr && !cmd_ready);
    assign wr_done = apb.psel && apb.penable && apb.pwrite && pready;

    // one-cycle command, sampled by the FSM on the edge ending the access phase
    always_comb begin
        cmd = '0;
        if (wr_done) begin
            case (apb.paddr)
                tetris_pkg::addr_ctrl: begin
                    cmd.start = apb.pwdata[0];
                    cmd.stop  = apb.pwdata[1];
                end
                tetris_pkg::addr_lock: begin
                    cmd.lock      = 1'b1;
                    cmd.lock_row  = apb.pwdata[4:0];
                    cmd.lock_mask = apb.pwdata[17:8];
                    cmd.lock_tile = tetris_pkg::tile_t'(apb.pwdata[23:20]);
                end
                tetris_pkg::addr_garbage: begin
                    cmd.garbage       = 1'b1;
                    cmd.garbage_count = apb.pwdata[4:0];
                    cmd.garbage_hole  = apb.pwdata[11:8];
                end
                default: ;
            endcase
        end
    end

    assign busy    = (state == tetris_pkg::st_clear) || (state == tetris_pkg::st_garbage);
    assign row_off = apb.paddr - tetris_pkg::addr_row_base;
    assign row_sel = row_off[6:2];
    assign row_hit = (apb.paddr >= tetris_pkg::addr_row_base) && !row_off[7] &&
                     (row_off[1:0] == 2'b00) && (row_sel < 5'(tetris_pkg::pf_rows));

    always_comb begin
        rd_mux = '0;
        case (apb.paddr)
            tetris_pkg::addr_status: rd_mux = {28'd0, busy, state};
            tetris_pkg::addr_lines:  rd_mux = {16'd0, lines_cleared};
            tetris_pkg::addr_timer:  rd_mux = {13'd0, game_time};
            default: begin
                if (row_hit) begin
                    rd_mux = {22'd0, row_masks[row_sel]};
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prdata <= '0;
        end else if (apb.psel && !apb.penable && !apb.pwrite) begin
            prdata <= rd_mux;
        end
    end

endmodule

// File: src/game_ctrl_fsm.sv
// commands act on the edge that completes their APB write
// lock and garbage commands are only honoured in play
`timescale 1ns/100ps

module game_ctrl_fsm (
    input  logic                           clk,
    input  logic                           rst_n,
    input  tetris_pkg::host_cmd_t          cmd,
    output logic                           cmd_ready,
    input  logic [tetris_pkg::pf_rows-1:0] full_rows,
    input  logic                           top_filled,
    output tetris_pkg::pf_op_t             pf_op,
    output tetris_pkg::game_state_t        state,
    output logic                           timer_run,
    output logic                           timer_restart
);

    tetris_pkg::game_state_t state_d;
    logic [4:0]              remaining_q;
    logic [4:0]              remaining_d;
    tetris_pkg::row_idx_t    low_idx;
    logic [3:0]              pf_hole_q;

    // bottom of the field is the highest index, so the last hit wins
    always_comb begin
        low_idx = '0;
        for (int r = 0; r < tetris_pkg::pf_rows; r++) begin
            if (full_rows[r]) begin
                low_idx = tetris_pkg::row_idx_t'(r);
            end
        end
    end

    always_comb begin
        pf_op         = '0;
        state_d       = state;
        remaining_d   = remaining_q;
        timer_restart = 1'b0;
        if (cmd.start) begin
            pf_op.clear_all = 1'b1;
            timer_restart   = 1'b1;
            remaining_d     = '0;
            state_d         = tetris_pkg::st_play;
        end else begin
            case (state)
                tetris_pkg::st_play: begin
                    if (cmd.stop) begin
                        state_d = tetris_pkg::st_idle;
                    end else if (cmd.lock) begin
                        pf_op.write_row = 1'b1;
                        pf_op.row       = cmd.lock_row;
                        pf_op.mask      = cmd.lock_mask;
                        pf_op.tile      = cmd.lock_tile;
                        state_d         = tetris_pkg::st_clear;
                    end else if (cmd.garbage) begin
                        remaining_d = cmd.garbage_count;
                        state_d     = tetris_pkg::st_garbage;
                    end
                end
                tetris_pkg::st_clear: begin
                    if (|full_rows) begin
                        pf_op.remove_row = 1'b1;
                        pf_op.remove_idx = low_idx;
                    end else begin
                        state_d = tetris_pkg::st_play;
                    end
                end
                tetris_pkg::st_garbage: begin
                    if (remaining_q == '0) begin
                        state_d = tetris_pkg::st_play;
                    end else if (top_filled) begin
                        state_d = tetris_pkg::st_over;
                    end else begin
                        pf_op.push_garbage = 1'b1;
                        pf_op.hole         = pf_hole_q;
                        remaining_d        = remaining_q - 5'd1;
                    end
                end
                default: ;
            endcase
        end
    end

    // hole column is held for the whole garbage burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= tetris_pkg::st_idle;
            remaining_q <= '0;
            pf_hole_q   <= '0;
        end else begin
            state       <= state_d;
            remaining_q <= remaining_d;
            if (cmd.garbage && state == tetris_pkg::st_play) begin
                pf_hole_q <= cmd.garbage_hole;
            end
        end
    end

    assign cmd_ready = (state != tetris_pkg::st_clear) && (state != tetris_pkg::st_garbage);
    assign timer_run = (state != tetris_pkg::st_idle) && (state != tetris_pkg::st_over);

endmodule

// File: src/sprint_timer.sv
// sprint clock, one centisecond every tick_cycles clocks while run is high
// stops at 63:59.99
`timescale 1ns/100ps

module sprint_timer #(
    parameter int unsigned tick_cycles = 500000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    input  logic                   restart,
    output tetris_pkg::game_time_t game_time
);

    localparam int unsigned pw = $clog2(tick_cycles + 1);

    logic [pw-1:0] presc_q;
    logic          tick;
    logic          at_max;
    logic          cs_wrap;
    logic          sec_wrap;

    assign at_max   = (game_time.minutes == 6'd63) && (game_time.seconds == 6'd59) &&
                      (game_time.centiseconds == 7'd99);
    assign tick     = run && (presc_q == pw'(tick_cycles - 1)) && !at_max;
    assign cs_wrap  = game_time.centiseconds == 7'd99;
    assign sec_wrap = game_time.seconds == 6'd59;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc_q   <= '0;
            game_time <= '0;
        end else if (restart) begin
            presc_q   <= '0;
            game_time <= '0;
        end else if (run) begin
            if (presc_q == pw'(tick_cycles - 1)) begin
                presc_q <= '0;
            end else begin
                presc_q <= presc_q + 1'b1;
            end
            // cascade cs -> s -> min
            if (tick) begin
                game_time.centiseconds <= cs_wrap ? 7'd0 : game_time.centiseconds + 7'd1;
                if (cs_wrap) begin
                    game_time.seconds <= sec_wrap ? 6'd0 : game_time.seconds + 6'd1;
                    if (sec_wrap) begin
                        game_time.minutes <= game_time.minutes + 6'd1;
                    end
                end
            end
        end
    end

endmodule

// File: src/playfield_store.sv
// locked playfield, all ops land on the next edge, outputs are combinational
// row writes outside the field and holes past the last column are ignored
`timescale 1ns/100ps

module playfield_store (
    input  logic                           clk,
    input  logic                           rst_n,
    input  tetris_pkg::pf_op_t             op,
    output logic [tetris_pkg::pf_rows-1:0] full_rows,
    output logic                           top_filled,
    output tetris_pkg::row_mask_t          row_masks [tetris_pkg::pf_rows],
    output logic [15:0]                    lines_cleared
);

    tetris_pkg::tile_t cells [tetris_pkg::pf_rows][tetris_pkg::pf_cols];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < tetris_pkg::pf_rows; r++) begin
                for (int c = 0; c < tetris_pkg::pf_cols; c++) begin
                    cells[r][c] <= tetris_pkg::tile_blank;
                end
            end
            lines_cleared <= '0;
        end else if (op.clear_all) begin
            for (int r = 0; r < tetris_pkg::pf_rows; r++) begin
                for (int c = 0; c < tetris_pkg::pf_cols; c++) begin
                    cells[r][c] <= tetris_pkg::tile_blank;
                end
            end
            lines_cleared <= '0;
        end else if (op.remove_row) begin
            // collapse everything above the removed row
            for (int r = 1; r < tetris_pkg::pf_rows; r++) begin
                if (r <= int'(op.remove_idx)) begin
                    cells[r] <= cells[r-1];
                end
            end
            for (int c = 0; c < tetris_pkg::pf_cols; c++) begin
                cells[0][c] <= tetris_pkg::tile_blank;
            end
            lines_cleared <= lines_cleared + 16'd1;
        end else if (op.push_garbage) begin
            for (int r = 0; r < tetris_pkg::pf_rows - 1; r++) begin
                cells[r] <= cells[r+1];
            end
            for (int c = 0; c < tetris_pkg::pf_cols; c++) begin
                cells[tetris_pkg::pf_rows-1][c] <= (c == int'(op.hole)) ?
                    tetris_pkg::tile_blank : tetris_pkg::tile_garbage;
            end
        end else if (op.write_row && (op.row < 5'(tetris_pkg::pf_rows))) begin
            for (int c = 0; c < tetris_pkg::pf_cols; c++) begin
                if (op.mask[c]) begin
                    cells[op.row][c] <= op.tile;
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < tetris_pkg::pf_rows; r++) begin
            for (int c = 0; c < tetris_pkg::pf_cols; c++) begin
                row_masks[r][c] = cells[r][c] != tetris_pkg::tile_blank;
            end
            full_rows[r] = &row_masks[r];
        end
    end

    assign top_filled = |row_masks[0];

endmodule

// File: src/tetris_core.sv
// playfield core behind an APB register bank, no error responses
// tick_cycles is the number of clocks per centisecond
`timescale 1ns/100ps

module tetris_core #(
    parameter int unsigned tick_cycles = 500000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  tetris_pkg::apb_req_t apb,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr
);

    tetris_pkg::host_cmd_t          cmd;
    logic                           cmd_ready;
    tetris_pkg::game_state_t        state;
    tetris_pkg::pf_op_t             pf_op;
    logic [tetris_pkg::pf_rows-1:0] full_rows;
    logic                           top_filled;
    tetris_pkg::row_mask_t          row_masks [tetris_pkg::pf_rows];
    logic [15:0]                    lines_cleared;
    logic                           timer_run;
    logic                           timer_restart;
    tetris_pkg::game_time_t         game_time;

    assign pslverr = 1'b0;

    apb_regs u_apb_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .apb           (apb),
        .prdata        (prdata),
        .pready        (pready),
        .cmd_ready     (cmd_ready),
        .cmd           (cmd),
        .state         (state),
        .lines_cleared (lines_cleared),
        .game_time     (game_time),
        .row_masks     (row_masks)
    );

    game_ctrl_fsm u_game_ctrl_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (cmd),
        .cmd_ready     (cmd_ready),
        .full_rows     (full_rows),
        .top_filled    (top_filled),
        .pf_op         (pf_op),
        .state         (state),
        .timer_run     (timer_run),
        .timer_restart (timer_restart)
    );

    sprint_timer #(
        .tick_cycles (tick_cycles)
    ) u_sprint_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (timer_run),
        .restart   (timer_restart),
        .game_time (game_time)
    );

    playfield_store u_playfield_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .op            (pf_op),
        .full_rows     (full_rows),
        .top_filled    (top_filled),
        .row_masks     (row_masks),
        .lines_cleared (lines_cleared)
    );

endmodule

// File: test/tb_tetris_core.sv
// runs tetris_core with tick_cycles of 4 so a centisecond is 4 clocks
// row masks are compared with a reference occupancy model held in this file
`timescale 1ns/100ps

module tb_tetris_core;

    localparam int timeout_cycles = 2000;
    localparam tetris_pkg::row_mask_t full_mask = '1;

    logic                 clk;
    logic                 rst_n;
    tetris_pkg::apb_req_t apb;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;

    tetris_pkg::row_mask_t   ref_rows [tetris_pkg::pf_rows];
    int                      ref_lines;
    tetris_pkg::game_state_t ref_state;
    logic [31:0]             rng_state;
    int                      checks;
    int                      errors;

    tetris_core #(
        .tick_cycles (4)
    ) dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb     (apb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #4 clk = ~clk;

    function logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // random mask that leaves the row short of full once ORed in
    function tetris_pkg::row_mask_t partial_mask(input tetris_pkg::row_mask_t existing);
        logic [31:0]           r;
        tetris_pkg::row_mask_t m;
        logic                  found;
        m = '0;
        found = 1'b0;
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            if (!found && ((existing | r[9:0]) != full_mask)) begin
                m = r[9:0];
                found = 1'b1;
            end
        end
        return m;
    endfunction

    function tetris_pkg::tile_t random_tile();
        logic [31:0] r;
        r = next_rand();
        return tetris_pkg::tile_t'(4'(r % 7) + 4'd1);
    endfunction

    // lowest full row goes first and the rows above drop by one
    function void collapse_full_rows();
        int r;
        r = tetris_pkg::pf_rows - 1;
        while (r >= 0) begin
            if (ref_rows[r] == full_mask) begin
                for (int k = r; k > 0; k--) begin
                    ref_rows[k] = ref_rows[k-1];
                end
                ref_rows[0] = '0;
                ref_lines++;
            end else begin
                r--;
            end
        end
    endfunction

    // returns 1 when a push finds row 0 occupied
    function logic push_garbage_rows(input int count, input int hole);
        logic topped;
        topped = 1'b0;
        for (int i = 0; i < count; i++) begin
            if (!topped && ref_rows[0] != '0) begin
                topped = 1'b1;
            end else if (!topped) begin
                for (int k = 0; k < tetris_pkg::pf_rows - 1; k++) begin
                    ref_rows[k] = ref_rows[k+1];
                end
                ref_rows[tetris_pkg::pf_rows-1] = full_mask & ~(tetris_pkg::row_mask_t'(1) << hole);
            end
        end
        return topped;
    endfunction

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(posedge clk);
        #1;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr;
        apb.pwdata  = data;
        @(posedge clk);
        #1;
        apb.penable = 1'b1;
        n = 0;
        while (!pready && n < timeout_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!pready) begin
            errors++;
            $display("APB write to 0x%02h got no pready within %0d cycles", addr, n);
        end
        check_value("apb_write", $sformatf("pslverr at 0x%02h", addr), 32'd0, 32'(pslverr));
        @(posedge clk);
        #1;
        apb = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        @(posedge clk);
        #1;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apb.paddr   = addr;
        apb.pwdata  = '0;
        @(posedge clk);
        #1;
        apb.penable = 1'b1;
        n = 0;
        while (!pready && n < timeout_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!pready) begin
            errors++;
            $display("APB read from 0x%02h got no pready within %0d cycles", addr, n);
        end
        check_value("apb_read", $sformatf("pslverr at 0x%02h", addr), 32'd0, 32'(pslverr));
        @(posedge clk);
        #1;
        data = prdata;
        apb = '0;
    endtask

    task automatic wait_idle_busy();
        logic [31:0] st;
        int          n;
        n = 0;
        apb_read(tetris_pkg::addr_status, st);
        while (st[3] && n < timeout_cycles) begin
            apb_read(tetris_pkg::addr_status, st);
            n++;
        end
        if (st[3]) begin
            errors++;
            $display("busy stayed set after %0d status reads", n);
        end
    endtask

    task automatic start_game();
        apb_write(tetris_pkg::addr_ctrl, 32'd1);
        foreach (ref_rows[r]) begin
            ref_rows[r] = '0;
        end
        ref_lines = 0;
        ref_state = tetris_pkg::st_play;
    endtask

    task automatic stop_game();
        apb_write(tetris_pkg::addr_ctrl, 32'd2);
        if (ref_state == tetris_pkg::st_play) begin
            ref_state = tetris_pkg::st_idle;
        end
    endtask

    task automatic lock_cells(input int row, input tetris_pkg::row_mask_t mask,
                              input tetris_pkg::tile_t tile);
        apb_write(tetris_pkg::addr_lock, {8'd0, tile, 2'd0, mask, 3'd0, 5'(row)});
        wait_idle_busy();
        if (ref_state == tetris_pkg::st_play) begin
            ref_rows[row] = ref_rows[row] | mask;
            collapse_full_rows();
        end
    endtask

    task automatic load_garbage(input int count, input int hole);
        apb_write(tetris_pkg::addr_garbage, {20'd0, 4'(hole), 3'd0, 5'(count)});
        wait_idle_busy();
        if (ref_state == tetris_pkg::st_play && push_garbage_rows(count, hole)) begin
            ref_state = tetris_pkg::st_over;
        end
    endtask

    task automatic compare_field(input string test_name);
        logic [31:0] rd;
        for (int r = 0; r < tetris_pkg::pf_rows; r++) begin
            apb_read(tetris_pkg::addr_row_base + 8'(4 * r), rd);
            check_value(test_name, $sformatf("row %0d", r), {22'd0, ref_rows[r]}, rd);
        end
    endtask

    task automatic check_status(input string test_name);
        logic [31:0] rd;
        apb_read(tetris_pkg::addr_status, rd);
        check_value(test_name, "status", {28'd0, 1'b0, ref_state}, rd);
    endtask

    task automatic check_lines(input string test_name);
        logic [31:0] rd;
        apb_read(tetris_pkg::addr_lines, rd);
        check_value(test_name, "lines", 32'(ref_lines), rd);
    endtask

    task automatic check_time_range(input tetris_pkg::game_time_t t);
        checks++;
        if (t.centiseconds > 7'd99 || t.seconds > 6'd59) begin
            errors++;
            $display("ERROR test_timer: expected fields in range, actual %0d:%0d.%0d",
                     t.minutes, t.seconds, t.centiseconds);
        end
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        check_status("test_reset");
        check_lines("test_reset");
        apb_read(tetris_pkg::addr_timer, rd);
        check_value("test_reset", "timer", 32'd0, rd);
        compare_field("test_reset");
    endtask

    task automatic test_lock_partial();
        int                    rows [4] = '{4, 9, 13, 17};
        tetris_pkg::row_mask_t m;
        // still idle here, so this lock must be dropped
        lock_cells(3, 10'h155, tetris_pkg::piece_t);
        compare_field("test_lock_partial");
        check_status("test_lock_partial");
        start_game();
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 2; j++) begin
                m = partial_mask(ref_rows[rows[i]]);
                lock_cells(rows[i], m, random_tile());
            end
        end
        compare_field("test_lock_partial");
        check_lines("test_lock_partial");
        check_status("test_lock_partial");
    endtask

    task automatic test_line_clear();
        start_game();
        lock_cells(19, partial_mask('0), random_tile());
        lock_cells(18, partial_mask('0), random_tile());
        lock_cells(17, partial_mask('0), random_tile());
        compare_field("test_line_clear");
        // completing row 19 pulls row 18 down into it
        lock_cells(19, ~ref_rows[19], random_tile());
        check_lines("test_line_clear");
        compare_field("test_line_clear");
        lock_cells(19, ~ref_rows[19], random_tile());
        check_lines("test_line_clear");
        compare_field("test_line_clear");
        check_status("test_line_clear");
    endtask

    task automatic test_garbage();
        logic [31:0] r;
        logic [31:0] rd;
        int          hole;
        start_game();
        lock_cells(19, partial_mask('0), random_tile());
        lock_cells(18, partial_mask('0), random_tile());
        r = next_rand();
        hole = int'(r % 10);
        load_garbage(3, hole);
        for (int i = 0; i < 3; i++) begin
            apb_read(tetris_pkg::addr_row_base + 8'(4 * (19 - i)), rd);
            check_value("test_garbage", "garbage row",
                        {22'd0, full_mask & ~(tetris_pkg::row_mask_t'(1) << hole)}, rd);
        end
        compare_field("test_garbage");
        load_garbage(2, (hole + 3) % 10);
        compare_field("test_garbage");
        check_lines("test_garbage");
        check_status("test_garbage");
    endtask

    task automatic test_top_out();
        tetris_pkg::row_mask_t m;
        start_game();
        // one cleared line so the restart below has a count to zero
        lock_cells(19, full_mask, random_tile());
        m = partial_mask('0);
        if (m == '0) begin
            m = 10'h001;
        end
        lock_cells(0, m, random_tile());
        load_garbage(2, 4);
        check_status("test_top_out");
        check_lines("test_top_out");
        compare_field("test_top_out");
        lock_cells(5, 10'h0ff, tetris_pkg::piece_o);
        compare_field("test_top_out");
        check_status("test_top_out");
        start_game();
        check_status("test_top_out");
        check_lines("test_top_out");
        compare_field("test_top_out");
    endtask

    task automatic test_timer();
        logic [31:0]            rd;
        tetris_pkg::game_time_t t1;
        tetris_pkg::game_time_t t2;
        stop_game();
        check_status("test_timer");
        apb_read(tetris_pkg::addr_timer, rd);
        t1 = rd[18:0];
        repeat (50) @(posedge clk);
        apb_read(tetris_pkg::addr_timer, rd);
        t2 = rd[18:0];
        check_value("test_timer", "held time", 32'(t1), 32'(t2));
        check_time_range(t1);
        check_time_range(t2);
        start_game();
        repeat (400) @(posedge clk);
        apb_read(tetris_pkg::addr_timer, rd);
        t1 = rd[18:0];
        checks++;
        if (t1 == '0 || t1.minutes != 6'd0 || t1.seconds >= 6'd2) begin
            errors++;
            $display("ERROR test_timer: expected time above 0 and below 2 s, actual %0d:%0d.%0d",
                     t1.minutes, t1.seconds, t1.centiseconds);
        end
        repeat (100) @(posedge clk);
        apb_read(tetris_pkg::addr_timer, rd);
        t2 = rd[18:0];
        checks++;
        if (t2 <= t1) begin
            errors++;
            $display("ERROR test_timer: expected above 0x%0h, actual 0x%0h", t1, t2);
        end
        check_time_range(t1);
        check_time_range(t2);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        apb = '0;
        rng_state = 32'd5;
        checks = 0;
        errors = 0;
        ref_lines = 0;
        ref_state = tetris_pkg::st_idle;
        foreach (ref_rows[r]) begin
            ref_rows[r] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_lock_partial();
        test_line_clear();
        test_garbage();
        test_top_out();
        test_timer();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
src/tetris_pkg.sv
src/apb_regs.sv
src/game_ctrl_fsm.sv
src/sprint_timer.sv
src/playfield_store.sv
src/tetris_core.sv
test/tb_tetris_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_tetris_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
